//--- rv_pipe_defines.svh
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

// ============================================================
// datapath and register file sizing
// ============================================================

// integer register width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_REG_COUNT 32

// bits needed to index one register.
`define RV_REG_ADDR_W 5

`endif

//--- rv_pipe_pkg.sv
`include "rv_pipe_defines.svh"

package rv_pipe_pkg;

    // ============================================================
    // encodings
    // ============================================================

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // register-register.
        opc_op_imm = 7'b0010011,  // register-immediate.
        opc_lui    = 7'b0110111
    } rv_opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_t;

    typedef enum logic {
        src1_reg  = 1'b0,
        src1_zero = 1'b1   // lui path.
    } alu_src1_t;

    typedef enum logic {
        src2_reg = 1'b0,
        src2_imm = 1'b1
    } alu_src2_t;

    // ============================================================
    // stage payloads
    // ============================================================

    typedef struct packed {
        logic [`RV_XLEN-1:0] word;
    } if_id_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_src1_t alu_src1;
        alu_src2_t alu_src2;
    } ctrl_ex_t;

    typedef struct packed {
        logic                      load_regfile;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
    } ctrl_wb_t;

    typedef struct packed {
        ctrl_ex_t            ctrl_ex;
        ctrl_wb_t            ctrl_wb;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_wb_t            ctrl_wb;
        logic [`RV_XLEN-1:0] result;
    } ex_wb_t;

endpackage

//--- stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in,
    output logic     out_valid,
    output payload_t out
);

    // flush wins over load so a stalled stage takes a bubble.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
            out       <= '0;  // zero is add/register/no-write.
        end else if (load) begin
            out_valid <= in_valid;
            out       <= in;
        end
    end

endmodule

//--- decoder.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module decoder
    import rv_pipe_pkg::*;
(
    input  if_id_t              instr,
    output ctrl_ex_t            ctrl_ex,
    output ctrl_wb_t            ctrl_wb,
    output logic [`RV_XLEN-1:0] imm,
    output logic                supported
);

    logic [`RV_XLEN-1:0] word;
    rv_opcode_t          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                alt;
    logic                f7_ok_reg;
    logic                f7_ok_imm;
    alu_op_t             f3_op;

    assign word   = instr.word;
    assign opcode = rv_opcode_t'(word[6:0]);
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];
    assign alt    = (funct7 == 7'b0100000);

    // only sub, sra and srai may set funct7[5].
    assign f7_ok_reg = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign f7_ok_imm = (funct3 != 3'b001 && funct3 != 3'b101) || (funct7 == 7'b0)
                       || (alt && funct3 == 3'b101);

    always_comb begin
        unique case (funct3)
            3'b000:  f3_op = (alt && opcode == opc_op) ? alu_sub : alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alt ? alu_sra : alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl_ex.alu_op       = alu_add;
        ctrl_ex.alu_src1     = src1_reg;
        ctrl_ex.alu_src2     = src2_reg;
        ctrl_wb.load_regfile = 1'b0;
        ctrl_wb.rs1          = '0;  // unused sources read as x0.
        ctrl_wb.rs2          = '0;
        ctrl_wb.rd           = word[11:7];
        imm                  = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
        supported            = 1'b0;
        case (opcode)
            opc_op: begin
                supported        = f7_ok_reg;
                ctrl_ex.alu_op   = f3_op;
                ctrl_wb.rs1      = word[19:15];
                ctrl_wb.rs2      = word[24:20];
            end
            opc_op_imm: begin
                supported        = f7_ok_imm;
                ctrl_ex.alu_op   = f3_op;
                ctrl_ex.alu_src2 = src2_imm;
                ctrl_wb.rs1      = word[19:15];
            end
            opc_lui: begin
                supported        = 1'b1;
                ctrl_ex.alu_src1 = src1_zero;
                ctrl_ex.alu_src2 = src2_imm;
                imm              = {word[31:12], 12'b0};
            end
            default: ;
        endcase
        ctrl_wb.load_regfile = supported;
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1,
    input  logic [`RV_REG_ADDR_W-1:0] rs2,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] rd,
    input  logic [`RV_XLEN-1:0]       wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // write-before-read, covers the ex/wb distance.
    assign rs1_data = (rs1 == '0) ? '0 :
                      (we && rd == rs1) ? wdata : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (we && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- alu_unit.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module alu_unit
    import rv_pipe_pkg::*;
(
    input  ctrl_ex_t            ctrl_ex,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] result
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;

    assign op_a  = (ctrl_ex.alu_src1 == src1_zero) ? '0 : rs1_data;
    assign op_b  = (ctrl_ex.alu_src2 == src2_imm) ? imm : rs2_data;
    assign shamt = op_b[4:0];  // low five bits only.

    always_comb begin
        unique case (ctrl_ex.alu_op)
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_or:   result = op_a | op_b;
            alu_xor:  result = op_a ^ op_b;
            alu_sll:  result = op_a << shamt;
            alu_srl:  result = op_a >> shamt;
            alu_sra:  result = $signed(op_a) >>> shamt;  // sign fill.
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            default:  result = op_a + op_b;
        endcase
    end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module hazard_unit
    import rv_pipe_pkg::*;
(
    input  logic                      id_valid,
    input  logic [`RV_REG_ADDR_W-1:0] id_rs1,
    input  logic [`RV_REG_ADDR_W-1:0] id_rs2,
    input  logic                      id_uses_rs2,
    input  logic                      ex_valid,
    input  ctrl_wb_t                  ex_ctrl_wb,
    output logic                      stall
);

    logic ex_writes;
    logic rs1_hit;
    logic rs2_hit;

    assign ex_writes = ex_valid && ex_ctrl_wb.load_regfile && (ex_ctrl_wb.rd != '0);
    assign rs1_hit   = (id_rs1 != '0) && (id_rs1 == ex_ctrl_wb.rd);
    assign rs2_hit   = id_uses_rs2 && (id_rs2 != '0) && (id_rs2 == ex_ctrl_wb.rd);

    // ex/wb distance is bypassed, so only id vs ex matters.
    assign stall = id_valid && ex_writes && (rs1_hit || rs2_hit);

endmodule

//--- rv_pipe_top.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_pipe_top
    import rv_pipe_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [`RV_XLEN-1:0]       instr,
    output logic                      instr_ready,
    output logic                      wb_valid,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]       wb_data
);

    if_id_t              if_id_q;
    logic                if_id_valid;
    ctrl_ex_t            id_ctrl_ex;
    ctrl_wb_t            id_ctrl_wb;
    logic [`RV_XLEN-1:0] id_imm;
    logic                id_supported;
    logic [`RV_XLEN-1:0] id_rs1_data;
    logic [`RV_XLEN-1:0] id_rs2_data;
    id_ex_t              id_ex_q;
    logic                id_ex_valid;
    logic [`RV_XLEN-1:0] ex_result;
    ex_wb_t              ex_wb_q;
    logic                ex_wb_valid;
    logic                stall;

    assign instr_ready = !stall;

    // ============================================================
    // fetch port to decode
    // ============================================================

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk, .rst,
        .load(!stall), .flush(1'b0),
        .in_valid(instr_valid), .in('{word: instr}),
        .out_valid(if_id_valid), .out(if_id_q)
    );

    decoder decoder_inst (
        .instr(if_id_q), .ctrl_ex(id_ctrl_ex), .ctrl_wb(id_ctrl_wb),
        .imm(id_imm), .supported(id_supported)
    );

    regfile regfile_inst (
        .clk, .rst,
        .rs1(id_ctrl_wb.rs1), .rs2(id_ctrl_wb.rs2),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
        .we(wb_valid), .rd(wb_rd), .wdata(wb_data)
    );

    hazard_unit hazard_inst (
        .id_valid(if_id_valid && id_supported),
        .id_rs1(id_ctrl_wb.rs1), .id_rs2(id_ctrl_wb.rs2),
        .id_uses_rs2(id_ctrl_ex.alu_src2 == src2_reg),
        .ex_valid(id_ex_valid), .ex_ctrl_wb(id_ex_q.ctrl_wb),
        .stall
    );

    // ============================================================
    // execute and writeback
    // ============================================================

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk, .rst,
        .load(1'b1), .flush(stall),  // bubble while id waits.
        .in_valid(if_id_valid),
        .in('{ctrl_ex: id_ctrl_ex, ctrl_wb: id_ctrl_wb, rs1_data: id_rs1_data,
              rs2_data: id_rs2_data, imm: id_imm}),
        .out_valid(id_ex_valid), .out(id_ex_q)
    );

    alu_unit alu_inst (
        .ctrl_ex(id_ex_q.ctrl_ex), .rs1_data(id_ex_q.rs1_data),
        .rs2_data(id_ex_q.rs2_data), .imm(id_ex_q.imm), .result(ex_result)
    );

    stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk, .rst,
        .load(1'b1), .flush(1'b0),
        .in_valid(id_ex_valid), .in('{ctrl_wb: id_ex_q.ctrl_wb, result: ex_result}),
        .out_valid(ex_wb_valid), .out(ex_wb_q)
    );

    // retire doubles as the regfile write.
    assign wb_valid = ex_wb_valid && ex_wb_q.ctrl_wb.load_regfile && (ex_wb_q.ctrl_wb.rd != '0);
    assign wb_rd    = ex_wb_q.ctrl_wb.rd;
    assign wb_data  = ex_wb_q.result;

endmodule

//--- rv_pipe_assertions.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_pipe_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      instr_ready,
    input logic                      wb_valid,
    input logic [`RV_REG_ADDR_W-1:0] wb_rd
);

    int failures = 0;

    // stage registers are clear after the first reset edge.
    wb_quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !wb_valid)
        else begin
            $error("retire port active while reset was asserted");
            failures++;
        end

    no_x0_retire: assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0)
        else begin
            $error("retire port raised for register x0");
            failures++;
        end

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> instr_ready)
        else begin
            $error("instr_ready low in the first cycle after reset");
            failures++;
        end

endmodule

//--- rv_pipe_checker.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_pipe_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [`RV_XLEN-1:0]       instr,
    input  logic                      instr_ready,
    input  logic                      wb_valid,
    input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]       wb_data,
    input  logic                      end_of_test,
    output int                        value_errors,
    output int                        other_errors,
    output int                        retired,
    output int                        pending
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } retire_t;

    retire_t             expected_q[$];
    logic [`RV_XLEN-1:0] model_regs [`RV_REG_COUNT];
    bit                  after_reset = 1'b0;
    bit                  reported = 1'b0;

    initial begin
        value_errors = 0;
        other_errors = 0;
        retired      = 0;
        pending      = 0;
    end

    // ============================================================
    // reference model
    // ============================================================

    function automatic logic [31:0] alu_model(input logic [2:0] funct3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'd0: alu_model = alt ? a - b : a + b;
            3'd1: alu_model = a << b[4:0];
            3'd2: alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: alu_model = (a < b) ? 32'd1 : 32'd0;
            3'd4: alu_model = a ^ b;
            3'd5: begin
                if (alt) begin
                    alu_model = $signed(a) >>> b[4:0];  // sign fill.
                end else begin
                    alu_model = a >> b[4:0];
                end
            end
            3'd6: alu_model = a | b;
            default: alu_model = a & b;
        endcase
    endfunction

    // runs one accepted word in order, true when it must retire.
    function automatic bit run_model(input logic [31:0] word, output retire_t entry);
        logic [2:0]  funct3;
        logic [31:0] a;
        logic [31:0] imm;
        logic        alt;
        logic        ok;
        funct3     = word[14:12];
        a          = model_regs[word[19:15]];
        imm        = {{20{word[31]}}, word[31:20]};
        alt        = (word[31:25] == 7'h20);
        entry.rd   = word[11:7];
        entry.data = '0;
        ok         = 1'b0;
        case (word[6:0])
            OPC_OP: begin
                ok = word[31:25] == 7'h00 || (alt && (funct3 == 3'd0 || funct3 == 3'd5));
                entry.data = alu_model(funct3, alt, a, model_regs[word[24:20]]);
            end
            OPC_OP_IMM: begin
                ok = (funct3 != 3'd1 && funct3 != 3'd5) || word[31:25] == 7'h00
                     || (alt && funct3 == 3'd5);
                entry.data = alu_model(funct3, alt && funct3 == 3'd5, a, imm);  // no subi.
            end
            OPC_LUI: begin
                ok = 1'b1;
                entry.data = {word[31:12], 12'h000};
            end
            default: ;
        endcase
        if (ok && entry.rd != '0) begin
            model_regs[entry.rd] = entry.data;
        end
        return ok && entry.rd != '0;
    endfunction

    // ============================================================
    // mid-cycle sampling of both ports
    // ============================================================

    always @(negedge clk) begin : watch
        retire_t exp_entry;
        retire_t new_entry;
        if (rst) begin
            if (wb_valid === 1'b1) begin
                $display("retire port active at %0t ns while in reset", $time);
                other_errors++;
            end
            expected_q.delete();
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            after_reset = 1'b1;
        end else begin
            if (after_reset && instr_ready !== 1'b1) begin
                $display("instr_ready was not high in the first cycle after reset");
                other_errors++;
            end
            after_reset = 1'b0;
            if (wb_valid === 1'b1) begin
                if (wb_rd == '0) begin
                    $display("retire of register x0 seen at %0t ns", $time);
                    other_errors++;
                end
                if (expected_q.size() == 0) begin
                    $display("retire at %0t ns with no instruction outstanding", $time);
                    other_errors++;
                end else begin
                    exp_entry = expected_q.pop_front();
                    retired++;
                    if (wb_rd !== exp_entry.rd) begin
                        $display("** Error at %0t ns: wb_rd expected %0d, got %0d",
                                 $time, exp_entry.rd, wb_rd);
                        value_errors++;
                    end
                    if (wb_data !== exp_entry.data) begin
                        $display("** Error at %0t ns: wb_data expected %h, got %h",
                                 $time, exp_entry.data, wb_data);
                        value_errors++;
                    end
                end
            end
            if (instr_valid === 1'b1 && instr_ready === 1'b1) begin
                if (run_model(instr, new_entry)) begin
                    expected_q.push_back(new_entry);
                end
            end
            if (end_of_test && !reported) begin
                reported = 1'b1;
                if (expected_q.size() != 0) begin
                    $display("%0d accepted instructions never retired", expected_q.size());
                    other_errors++;
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

//--- tb_rv_pipe.sv
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module tb_rv_pipe;

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int SAMPLE_DELAY = 5;  // lands 2 ns before the next edge.
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 400;
    localparam int NUM_BAD      = 20;
    localparam int MAX_IDLE     = 2;
    localparam int DRAIN_LIMIT  = 16;  // last retire comes within a few cycles.
    // worst case per word is stall, accept and idle, about 3000 in all.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_INSTR + NUM_BAD) * (4 + MAX_IDLE) + 464;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic                      clk;
    logic                      rst;
    logic                      instr_valid;
    logic [`RV_XLEN-1:0]       instr;
    logic                      instr_ready;
    logic                      wb_valid;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      end_of_test;
    int                        value_errors;
    int                        other_errors;
    int                        retired;
    int                        pending;
    int                        assert_errors;
    int                        cycle_count = 0;

    rv_pipe_top rv_pipe_top_inst (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    rv_pipe_checker retire_checker (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .end_of_test(end_of_test),
        .value_errors(value_errors), .other_errors(other_errors),
        .retired(retired), .pending(pending)
    );

    bind rv_pipe_top rv_pipe_assertions rv_pipe_assertions_inst (
        .clk(clk), .rst(rst), .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_rd(wb_rd)
    );

    assign assert_errors = rv_pipe_top_inst.rv_pipe_assertions_inst.failures;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d retires outstanding",
                     cycle_count, pending);
            $display("Verification failed");
            $finish;
        end
    end

    // ============================================================
    // instruction words
    // ============================================================

    function automatic logic [31:0] reg_op_word(input logic [6:0] funct7,
                                                input logic [2:0] funct3, input logic [4:0] rd);
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = 5'($urandom_range(0, 7));  // x0..x7 keeps hazards frequent.
        rs2 = 5'($urandom_range(0, 7));
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] imm_op_word(input logic [11:0] imm,
                                                input logic [2:0] funct3, input logic [4:0] rd);
        logic [4:0] rs1;
        rs1 = 5'($urandom_range(0, 7));
        return {imm, rs1, funct3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] pick_instruction();
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [4:0]  shamt;
        rd    = 5'($urandom_range(0, 7));
        imm   = 12'($urandom);
        shamt = 5'($urandom);
        case ($urandom_range(0, 19))
            0:  return reg_op_word(7'h00, 3'd0, rd);  // add.
            1:  return reg_op_word(7'h20, 3'd0, rd);  // sub.
            2:  return reg_op_word(7'h00, 3'd1, rd);
            3:  return reg_op_word(7'h00, 3'd2, rd);
            4:  return reg_op_word(7'h00, 3'd3, rd);
            5:  return reg_op_word(7'h00, 3'd4, rd);
            6:  return reg_op_word(7'h00, 3'd5, rd);
            7:  return reg_op_word(7'h20, 3'd5, rd);  // sra.
            8:  return reg_op_word(7'h00, 3'd6, rd);
            9:  return reg_op_word(7'h00, 3'd7, rd);
            10: return imm_op_word(imm, 3'd0, rd);
            11: return imm_op_word(imm, 3'd2, rd);
            12: return imm_op_word(imm, 3'd3, rd);
            13: return imm_op_word(imm, 3'd4, rd);
            14: return imm_op_word(imm, 3'd6, rd);
            15: return imm_op_word(imm, 3'd7, rd);
            16: return imm_op_word({7'h00, shamt}, 3'd1, rd);
            17: return imm_op_word({7'h00, shamt}, 3'd5, rd);
            18: return imm_op_word({7'h20, shamt}, 3'd5, rd);  // srai.
            default: return {20'($urandom), rd, OPC_LUI};
        endcase
    endfunction

    // load, store, branch and jal are outside the subset.
    function automatic logic [31:0] pick_unsupported();
        logic [31:0] word;
        word = $urandom;
        case ($urandom_range(0, 3))
            0:       word[6:0] = 7'b0000011;
            1:       word[6:0] = 7'b0100011;
            2:       word[6:0] = 7'b1100011;
            default: word[6:0] = 7'b1101111;
        endcase
        return word;
    endfunction

    // ============================================================
    // port driving
    // ============================================================

    task automatic send_word(input logic [31:0] word);
        bit accepted;
        accepted    = 1'b0;
        instr       = word;
        instr_valid = 1'b1;
        while (!accepted) begin
            #(SAMPLE_DELAY);
            accepted = instr_ready;
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int count);
        instr_valid = 1'b0;
        repeat (count) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    initial begin : main
        int good_sent;
        int bad_sent;
        int drain_cycles;
        int total_errors;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        end_of_test = 1'b0;
        good_sent   = 0;
        bad_sent    = 0;
        void'($urandom(32'h150b));
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        while (good_sent < NUM_INSTR) begin
            if (bad_sent < NUM_BAD && $urandom_range(0, 19) == 0) begin
                send_word(pick_unsupported());
                bad_sent++;
            end else begin
                send_word(pick_instruction());
                good_sent++;
            end
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles(int'($urandom_range(1, MAX_IDLE)));
            end
        end
        drain_cycles = 0;
        while (pending != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (8) @(posedge clk);  // catch stray retires.
        end_of_test = 1'b1;
        repeat (2) @(posedge clk);
        total_errors = value_errors + other_errors + assert_errors;
        $display("%0d retires checked, errors: %0d value, %0d protocol, %0d assertion",
                 retired, value_errors, other_errors, assert_errors);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
rv_pipe_pkg.sv
stage_reg.sv
decoder.sv
regfile.sv
alu_unit.sv
hazard_unit.sv
rv_pipe_top.sv
rv_pipe_assertions.sv
rv_pipe_checker.sv
tb_rv_pipe.sv

//--- run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --top-module tb_rv_pipe -f compile.f -o sim_rv_pipe; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_pipe +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi
exit 0
